// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_memory_subsystem
FILELIST  ?= src.f
RUNFLAGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNFLAGS)

clean:
	rm -rf obj_dir

// File: core_pkg.sv
/* Shared types and constants for the memory stage and its data RAM.
   Accesses must be naturally aligned; addresses above the RAM size wrap. */

package core_pkg;

    // ==============================
    // Widths that carry a meaning
    // ==============================

    // Data or byte address word
    typedef logic [31:0] word_t;

    // One strobe bit per byte lane
    typedef logic [3:0] strb_t;

    // Destination register number
    typedef logic [4:0] reg_addr_t;

    // ==============================
    // Operations and stage states
    // ==============================

    // OP_NONE passes the ALU result straight through
    typedef enum logic [3:0] {
        OP_NONE,
        LOAD_WORD,
        LOAD_HALF,
        LOAD_BYTE,
        LOAD_HALF_UNSIGNED,
        LOAD_BYTE_UNSIGNED,
        STORE_WORD,
        STORE_HALF,
        STORE_BYTE
    } op_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_WAIT,
        READ_WAIT
    } stage_state_t;

    // ==============================
    // Memory size
    // ==============================

    // 256 words, selected by byte address bits [9:2]
    localparam int RAM_ADDR_BITS = 8;

    // Operation classification
    function automatic logic is_load(input op_t op);
        return op inside {LOAD_WORD, LOAD_HALF, LOAD_BYTE,
                          LOAD_HALF_UNSIGNED, LOAD_BYTE_UNSIGNED};
    endfunction

    function automatic logic is_store(input op_t op);
        return op inside {STORE_WORD, STORE_HALF, STORE_BYTE};
    endfunction

endpackage

// File: data_ram.sv
/* Word-wide data RAM, bus slave with one-cycle responses and byte strobes.
   Byte address bits [9:2] select the word; higher bits are ignored. */
`timescale 1ns/1ps

module data_ram import core_pkg::*; (
    input  logic  aclk,
    input  logic  aresetn,
    // Write
    input  logic  awvalid,
    output logic  awready,
    input  word_t awaddr,
    input  word_t wdata,
    input  strb_t wstrb,
    output logic  bvalid,
    input  logic  bready,
    // Read
    input  logic  arvalid,
    output logic  arready,
    input  word_t araddr,
    output logic  rvalid,
    input  logic  rready,
    output word_t rdata
);

    localparam int DEPTH = 2 ** RAM_ADDR_BITS;

    word_t mem [DEPTH];

    logic [RAM_ADDR_BITS-1:0] wr_index;
    logic [RAM_ADDR_BITS-1:0] rd_index;

    // Contents start cleared
    initial begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = '0;
    end

    assign wr_index = awaddr[RAM_ADDR_BITS+1:2];
    assign rd_index = araddr[RAM_ADDR_BITS+1:2];

    // No new request while a response is still waiting
    assign awready = !bvalid;
    assign arready = !rvalid;

    // ==============================
    // Write path
    // ==============================

    always_ff @(posedge aclk) begin
        if (awvalid && awready) begin
            for (int lane = 0; lane < 4; lane++)
                if (wstrb[lane])
                    mem[wr_index][8*lane +: 8] <= wdata[8*lane +: 8];
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn)
            bvalid <= 1'b0;
        else if (awvalid && awready)
            bvalid <= 1'b1;
        else if (bready)
            bvalid <= 1'b0;
    end

    // ==============================
    // Read path
    // ==============================

    always_ff @(posedge aclk) begin
        if (arvalid && arready)
            rdata <= mem[rd_index];
    end

    always_ff @(posedge aclk) begin
        if (!aresetn)
            rvalid <= 1'b0;
        else if (arvalid && arready)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

endmodule

// File: mem_lane_align.sv
/* Byte-lane placement for stores and load extension, purely combinational.
   Only naturally aligned halves and words give meaningful results. */
`timescale 1ns/1ps

module mem_lane_align import core_pkg::*; (
    input  op_t        op,
    input  logic [1:0] addr_low,
    input  word_t      store_data,
    output word_t      wdata,
    output strb_t      wstrb,
    input  op_t        load_op,
    input  logic [1:0] load_addr_low,
    input  word_t      rdata,
    output word_t      load_data
);

    // ==============================
    // Store side
    // ==============================

    always_comb begin
        wdata = store_data;
        wstrb = '0;
        case (op)
            STORE_WORD: begin
                wstrb = 4'b1111;
            end
            STORE_HALF: begin
                // Upper half when address bit 1 is set
                wdata = addr_low[1] ? (store_data << 16) : store_data;
                wstrb = addr_low[1] ? 4'b1100 : 4'b0011;
            end
            STORE_BYTE: begin
                wdata = store_data << {addr_low, 3'b000};
                wstrb = 4'b0001 << addr_low;
            end
            default: begin
                wdata = store_data;
                wstrb = '0;
            end
        endcase
    end

    // ==============================
    // Load side
    // ==============================

    logic [15:0] sel_half;
    logic [7:0]  sel_byte;

    assign sel_half = load_addr_low[1] ? rdata[31:16] : rdata[15:0];
    assign sel_byte = rdata[8*load_addr_low +: 8];

    always_comb begin
        case (load_op)
            LOAD_HALF:          load_data = {{16{sel_half[15]}}, sel_half};
            LOAD_BYTE:          load_data = {{24{sel_byte[7]}}, sel_byte};
            LOAD_HALF_UNSIGNED: load_data = {16'h0000, sel_half};
            LOAD_BYTE_UNSIGNED: load_data = {24'h000000, sel_byte};
            default:            load_data = rdata;
        endcase
    end

endmodule

// File: memory_stage.sv
/* Memory-access pipeline stage, one request in flight at a time.
   Data must be naturally aligned; the bus never returns error responses. */
`timescale 1ns/1ps

module memory_stage import core_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,
    // Request stream
    input  logic      source_valid,
    output logic      source_ready,
    input  op_t       source_op,
    input  word_t     source_alu,
    input  word_t     source_rs2,
    input  reg_addr_t source_rd,
    // Write-back stream
    output logic      sink_valid,
    input  logic      sink_ready,
    output op_t       sink_op,
    output reg_addr_t sink_rd,
    output word_t     sink_data,
    // Bus master
    output logic      awvalid,
    input  logic      awready,
    output word_t     awaddr,
    output word_t     wdata,
    output strb_t     wstrb,
    input  logic      bvalid,
    output logic      bready,
    output logic      arvalid,
    input  logic      arready,
    output word_t     araddr,
    input  logic      rvalid,
    output logic      rready,
    input  word_t     rdata
);

    stage_state_t state;

    logic accept;
    logic wr_done;
    logic rd_done;

    // Request registers, captured on acceptance
    op_t       req_op;
    reg_addr_t req_rd;
    word_t     req_addr;
    word_t     req_wdata;
    strb_t     req_wstrb;

    word_t lane_wdata;
    strb_t lane_wstrb;
    word_t load_data;

    assign source_ready = (state == IDLE) && sink_ready;
    assign accept       = source_valid && source_ready;
    assign wr_done      = bvalid && bready;
    assign rd_done      = rvalid && rready;

    mem_lane_align u_align (
        .op            (source_op),
        .addr_low      (source_alu[1:0]),
        .store_data    (source_rs2),
        .wdata         (lane_wdata),
        .wstrb         (lane_wstrb),
        .load_op       (req_op),
        .load_addr_low (req_addr[1:0]),
        .rdata         (rdata),
        .load_data     (load_data)
    );

    // ==============================
    // Stage FSM
    // ==============================

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept && is_store(source_op))
                        state <= WRITE_WAIT;
                    else if (accept && is_load(source_op))
                        state <= READ_WAIT;
                end
                WRITE_WAIT: if (wr_done) state <= IDLE;
                READ_WAIT:  if (rd_done) state <= IDLE;
                default:    state <= IDLE;
            endcase
        end
    end

    // ==============================
    // Bus requests
    // ==============================

    always_ff @(posedge aclk) begin
        if (accept) begin
            req_op    <= source_op;
            req_rd    <= source_rd;
            req_addr  <= source_alu;
            req_wdata <= lane_wdata;
            req_wstrb <= lane_wstrb;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            awvalid <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            if (accept && is_store(source_op))
                awvalid <= 1'b1;
            else if (awready)
                awvalid <= 1'b0;
            if (accept && is_load(source_op))
                arvalid <= 1'b1;
            else if (arready)
                arvalid <= 1'b0;
        end
    end

    assign awaddr = req_addr;
    assign araddr = req_addr;
    assign wdata  = req_wdata;
    assign wstrb  = req_wstrb;

    // Response stays pending while the write-back side is stalled
    assign bready = (state == WRITE_WAIT);
    assign rready = sink_ready;

    // ==============================
    // Write-back register
    // ==============================

    always_ff @(posedge aclk) begin
        if (!aresetn)
            sink_valid <= 1'b0;
        else if ((accept && !is_load(source_op)) || rd_done)
            sink_valid <= 1'b1;
        else if (sink_ready)
            sink_valid <= 1'b0;
    end

    always_ff @(posedge aclk) begin
        if (rd_done) begin
            sink_op   <= req_op;
            sink_rd   <= req_rd;
            sink_data <= load_data;
        end else if (accept && !is_load(source_op)) begin
            // Pass-through and stores carry the ALU value
            sink_op   <= source_op;
            sink_rd   <= source_rd;
            sink_data <= source_alu;
        end
    end

endmodule

// File: memory_subsystem.sv
/* Memory stage with its data RAM attached, for stand-alone testing. */
`timescale 1ns/1ps

module memory_subsystem import core_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      source_valid,
    output logic      source_ready,
    input  op_t       source_op,
    input  word_t     source_alu,
    input  word_t     source_rs2,
    input  reg_addr_t source_rd,
    output logic      sink_valid,
    input  logic      sink_ready,
    output op_t       sink_op,
    output reg_addr_t sink_rd,
    output word_t     sink_data
);

    // Bus between stage and RAM
    logic  awvalid, awready, bvalid, bready;
    logic  arvalid, arready, rvalid, rready;
    word_t awaddr, wdata, araddr, rdata;
    strb_t wstrb;

    memory_stage u_stage (
        .aclk, .aresetn,
        .source_valid, .source_ready, .source_op, .source_alu, .source_rs2, .source_rd,
        .sink_valid, .sink_ready, .sink_op, .sink_rd, .sink_data,
        .awvalid, .awready, .awaddr, .wdata, .wstrb, .bvalid, .bready,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata
    );

    data_ram u_ram (
        .aclk, .aresetn,
        .awvalid, .awready, .awaddr, .wdata, .wstrb, .bvalid, .bready,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata
    );

endmodule

// File: memory_subsystem_assertions.sv
/* Shadow-model checker for the write-back stream, bound to memory_subsystem.
   Assumes aligned requests that follow valid/ready; at most 16 results in flight. */
`timescale 1ns/1ps

module memory_subsystem_assertions import core_pkg::*; (
    input logic      aclk,
    input logic      aresetn,
    input logic      source_valid,
    input logic      source_ready,
    input op_t       source_op,
    input word_t     source_alu,
    input word_t     source_rs2,
    input reg_addr_t source_rd,
    input logic      sink_valid,
    input logic      sink_ready,
    input op_t       sink_op,
    input reg_addr_t sink_rd,
    input word_t     sink_data
);

    word_t     shadow [256];
    word_t     exp_data [16];
    op_t       exp_op [16];
    reg_addr_t exp_rd [16];
    logic [3:0] wr_ptr;
    logic [3:0] rd_ptr;
    int        error_count = 0;

    logic      accept;
    logic      direct_accept;
    word_t     head_data;
    op_t       head_op;
    reg_addr_t head_rd;

    initial begin
        for (int i = 0; i < 256; i++)
            shadow[i] = '0;
    end

    // Word with the store's lanes merged in
    function automatic word_t merge_store(input op_t op, input word_t old,
                                          input logic [1:0] lo, input word_t data);
        word_t w;
        w = old;
        case (op)
            STORE_WORD: w = data;
            STORE_HALF: w[16*lo[1] +: 16] = data[15:0];
            STORE_BYTE: w[8*lo +: 8] = data[7:0];
            default:    w = old;
        endcase
        return w;
    endfunction

    // Expected write-back value; non-loads carry the ALU value
    function automatic word_t result_of(input op_t op, input word_t w,
                                        input logic [1:0] lo, input word_t alu);
        logic [15:0] h;
        logic [7:0]  b;
        h = w[16*lo[1] +: 16];
        b = w[8*lo +: 8];
        case (op)
            LOAD_WORD:          return w;
            LOAD_HALF:          return {{16{h[15]}}, h};
            LOAD_BYTE:          return {{24{b[7]}}, b};
            LOAD_HALF_UNSIGNED: return {16'h0000, h};
            LOAD_BYTE_UNSIGNED: return {24'h000000, b};
            default:            return alu;
        endcase
    endfunction

    assign accept        = source_valid && source_ready;
    assign direct_accept = accept && (source_op inside {OP_NONE, STORE_WORD, STORE_HALF,
                                                        STORE_BYTE});
    assign head_data = exp_data[rd_ptr];
    assign head_op   = exp_op[rd_ptr];
    assign head_rd   = exp_rd[rd_ptr];

    // ==============================
    // Shadow memory and result queue
    // ==============================

    always @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (accept) begin
                exp_data[wr_ptr] <= result_of(source_op, shadow[source_alu[9:2]],
                                              source_alu[1:0], source_alu);
                exp_op[wr_ptr]   <= source_op;
                exp_rd[wr_ptr]   <= source_rd;
                shadow[source_alu[9:2]] <= merge_store(source_op, shadow[source_alu[9:2]],
                                                       source_alu[1:0], source_rs2);
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (sink_valid && sink_ready)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // ==============================
    // Write-back checks
    // ==============================

    a_reset_quiet: assert property (@(posedge aclk) !aresetn |=> !sink_valid)
        else begin
            error_count++;
            $error("sink_valid is high during reset or on the first edge after it");
        end

    a_direct_latency: assert property (@(posedge aclk) disable iff (!aresetn)
        direct_accept |=> sink_valid)
        else begin
            error_count++;
            $error("Pass-through or store result did not appear one edge after acceptance");
        end

    a_no_extra: assert property (@(posedge aclk) disable iff (!aresetn)
        sink_valid |-> wr_ptr != rd_ptr)
        else begin
            error_count++;
            $error("Write-back result appeared with no request waiting for it");
        end

    // Idle stage with an empty write-back register owes no results
    a_none_lost: assert property (@(posedge aclk) disable iff (!aresetn)
        source_ready && !sink_valid |-> wr_ptr == rd_ptr)
        else begin
            error_count++;
            $error("An accepted request finished without a write-back result");
        end

    a_data: assert property (@(posedge aclk) disable iff (!aresetn)
        sink_valid |-> sink_data == head_data)
        else begin
            error_count++;
            $error("Fail at %0t: sink_data is %h, expected %h", $time,
                   $sampled(sink_data), $sampled(head_data));
        end

    a_rd: assert property (@(posedge aclk) disable iff (!aresetn)
        sink_valid |-> sink_rd == head_rd)
        else begin
            error_count++;
            $error("Fail at %0t: sink_rd is %0d, expected %0d", $time,
                   $sampled(sink_rd), $sampled(head_rd));
        end

    a_op: assert property (@(posedge aclk) disable iff (!aresetn)
        sink_valid |-> sink_op == head_op)
        else begin
            error_count++;
            $error("Fail at %0t: sink_op is %0d, expected %0d", $time,
                   $sampled(sink_op), $sampled(head_op));
        end

    a_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        sink_valid && !sink_ready |=> sink_valid && $stable(sink_data)
                                      && $stable(sink_rd) && $stable(sink_op))
        else begin
            error_count++;
            $error("Write-back output changed while sink_ready was low");
        end

    a_stall_blocks: assert property (@(posedge aclk) disable iff (!aresetn)
        sink_valid && !sink_ready |-> !source_ready)
        else begin
            error_count++;
            $error("source_ready is high while the write-back stream is stalled");
        end

endmodule

bind memory_subsystem memory_subsystem_assertions u_checks (.*);

// File: src.f
core_pkg.sv
mem_lane_align.sv
memory_stage.sv
data_ram.sv
memory_subsystem.sv
memory_subsystem_assertions.sv
tb_memory_subsystem.sv

// File: tb_memory_subsystem.sv
/* Drives directed and random requests with random back-pressure into memory_subsystem.
   Results are checked by the bound assertion module. */
`timescale 1ns/1ps

module tb_memory_subsystem import core_pkg::*; ();

    localparam int TIMEOUT         = 50;
    localparam int RANDOM_REQUESTS = 400;

    logic      aclk = 1'b0;
    logic      aresetn;
    logic      source_valid;
    logic      source_ready;
    op_t       source_op;
    word_t     source_alu;
    word_t     source_rs2;
    reg_addr_t source_rd;
    logic      sink_valid;
    logic      sink_ready;
    op_t       sink_op;
    reg_addr_t sink_rd;
    word_t     sink_data;

    logic  stall_enable = 1'b0;
    word_t rng_state = 32'h30a6bc52;

    memory_subsystem dut (.*);

    always #4 aclk = ~aclk;

    function automatic word_t xorshift32(input word_t x);
        word_t v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    function word_t next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic abort_run(input string reason);
        $display("RESULT: FAIL");
        $fatal(1, "%s", reason);
    endtask

    // Low about one cycle in four while stalls are on
    task automatic drive_sink_ready();
        sink_ready = !stall_enable || (next_random() % 4 != 0);
    endtask

    task automatic send_request(input op_t op, input word_t alu, input word_t rs2,
                                input reg_addr_t rd);
        int   cycles;
        logic done;
        cycles       = 0;
        done         = 1'b0;
        source_valid = 1'b1;
        source_op    = op;
        source_alu   = alu;
        source_rs2   = rs2;
        source_rd    = rd;
        while (!done) begin
            // Handshake settles well before the next rising edge
            @(negedge aclk);
            done = source_ready;
            @(posedge aclk);
            #1;
            drive_sink_ready();
            cycles++;
            if (!done && cycles > TIMEOUT)
                abort_run("Timeout while waiting for a request to be accepted");
        end
        source_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge aclk);
        while (sink_valid || !source_ready) begin
            @(posedge aclk);
            #1;
            drive_sink_ready();
            cycles++;
            if (cycles > TIMEOUT)
                abort_run("Timeout while waiting for the stage to drain");
            @(negedge aclk);
        end
    endtask

    always @(negedge aclk) begin
        if (dut.u_checks.error_count != 0)
            abort_run("A write-back assertion failed");
    end

    initial begin
        word_t r;
        op_t   op;
        word_t addr;
        aresetn      = 1'b0;
        source_valid = 1'b0;
        source_op    = OP_NONE;
        source_alu   = '0;
        source_rs2   = '0;
        source_rd    = '0;
        sink_ready   = 1'b1;
        repeat (3) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        // ==============================
        // Directed requests
        // ==============================
        send_request(OP_NONE, 32'hcafe_0123, 32'h0, 5'd1);
        send_request(LOAD_WORD, 32'h0000_00fc, 32'h0, 5'd2);
        send_request(STORE_WORD, 32'h0000_0040, 32'h80f0_7f85, 5'd3);
        send_request(LOAD_WORD, 32'h0000_0040, 32'h0, 5'd4);
        // Lane merges give 1234_aa85
        send_request(STORE_BYTE, 32'h0000_0041, 32'h0000_00aa, 5'd5);
        send_request(STORE_HALF, 32'h0000_0042, 32'h0000_1234, 5'd6);
        send_request(LOAD_WORD, 32'h0000_0040, 32'h0, 5'd7);
        send_request(LOAD_BYTE, 32'h0000_0040, 32'h0, 5'd8);
        send_request(LOAD_BYTE_UNSIGNED, 32'h0000_0041, 32'h0, 5'd9);
        send_request(LOAD_HALF, 32'h0000_0040, 32'h0, 5'd10);
        send_request(LOAD_HALF_UNSIGNED, 32'h0000_0040, 32'h0, 5'd11);
        send_request(LOAD_HALF, 32'h0000_0042, 32'h0, 5'd12);

        // ==============================
        // Random mix with back-pressure
        // ==============================
        stall_enable = 1'b1;
        for (int i = 0; i < RANDOM_REQUESTS; i++) begin
            r    = next_random();
            op   = op_t'(r % 9);
            addr = {24'h0, r[13:8], 2'b00};
            if (op inside {LOAD_BYTE, LOAD_BYTE_UNSIGNED, STORE_BYTE})
                addr[1:0] = r[17:16];
            else if (op inside {LOAD_HALF, LOAD_HALF_UNSIGNED, STORE_HALF})
                addr[1] = r[17];
            else if (op == OP_NONE)
                addr = next_random();
            send_request(op, addr, next_random(), r[28:24]);
        end

        stall_enable = 1'b0;
        wait_idle();
        // Checker samples the drained stage on this edge
        @(posedge aclk);
        #1;
        if (dut.u_checks.error_count != 0) begin
            abort_run("A write-back assertion failed");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule
